//--- design/cfg_access_fsm.sv
// Configuration access FSM
`timescale 1ns/100ps

module cfg_access_fsm (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     cfg_req_i,
  input  logic                     cfg_we_i,
  input  pulp_mbox_pkg::cfg_addr_t cfg_addr_i,
  input  pulp_mbox_pkg::cfg_data_t cfg_wdata_i,
  output logic                     cfg_ack_o,
  output logic                     cfg_err_o,
  output pulp_mbox_pkg::cfg_data_t cfg_rdata_o,
  cfg_bus_if.master                win0,
  cfg_bus_if.master                win1
);
  import pulp_mbox_pkg::*;

  cfg_state_e state_q, state_d;
  cfg_addr_t  addr_q;
  cfg_data_t  wdata_q;
  logic       we_q;
  logic       hit0, hit1;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CFG_IDLE:   if (cfg_req_i) state_d = CFG_ACCESS;
      CFG_ACCESS: state_d = CFG_RESP;
      CFG_RESP:   state_d = CFG_IDLE;
      default:    state_d = CFG_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= CFG_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // requests arriving while busy are dropped here
  always_ff @(posedge clk_i) begin
    if (state_q == CFG_IDLE && cfg_req_i) begin
      addr_q  <= cfg_addr_i;
      we_q    <= cfg_we_i;
      wdata_q <= cfg_wdata_i;
    end
  end

  // unsigned wrap makes addresses below the base miss too
  assign hit0 = (addr_q - WIN0_BASE) < WIN_SIZE;
  assign hit1 = (addr_q - WIN1_BASE) < WIN_SIZE;

  assign win0.sel   = (state_q == CFG_ACCESS) && hit0;
  assign win0.we    = we_q;
  assign win0.offs  = addr_q[WIN_OFFS_W-1:0];
  assign win0.wdata = wdata_q;

  assign win1.sel   = (state_q == CFG_ACCESS) && hit1;
  assign win1.we    = we_q;
  assign win1.offs  = addr_q[WIN_OFFS_W-1:0];
  assign win1.wdata = wdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_ack_o <= 1'b0;
      cfg_err_o <= 1'b0;
    end else begin
      cfg_ack_o <= (state_q == CFG_RESP);
      cfg_err_o <= (state_q == CFG_RESP) && !(hit0 || hit1);
    end
  end

  // window rdata was registered one cycle after sel
  always_ff @(posedge clk_i) begin
    if (state_q == CFG_RESP) begin
      if (we_q) begin
        cfg_rdata_o <= '0;
      end else if (hit0) begin
        cfg_rdata_o <= win0.rdata;
      end else if (hit1) begin
        cfg_rdata_o <= win1.rdata;
      end else begin
        cfg_rdata_o <= '0;
      end
    end
  end

endmodule

//--- design/mbox_fifo.sv
// Mailbox word storage
`timescale 1ns/100ps

module mbox_fifo (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     push_i,
  input  pulp_mbox_pkg::cfg_data_t push_data_i,
  output logic                     full_o,
  mbox_rd_if.fifo                  rd
);
  import pulp_mbox_pkg::*;

  cfg_data_t             mem_q [MBOX_DEPTH];
  logic [MBOX_PTR_W-1:0] wr_ptr_q;
  logic [MBOX_PTR_W-1:0] rd_ptr_q;
  mbox_level_t           level_q;
  logic                  push_ok;
  logic                  pop_ok;

  assign full_o   = (level_q == MBOX_LEVEL_W'(MBOX_DEPTH));
  assign rd.empty = (level_q == '0);
  assign rd.level = level_q;
  // head word, seen before the pop
  assign rd.rdata = mem_q[rd_ptr_q];

  // a full mailbox drops the word even if a pop comes with it
  assign push_ok = push_i && !full_o;
  assign pop_ok  = rd.pop && !rd.empty;

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

endmodule

//--- design/mbox_irq_timer.sv
// Mailbox host interrupt
`timescale 1ns/100ps

module mbox_irq_timer (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  mbox_rd_if.monitor                 rd,
  input  logic                       irq_en_i,
  input  pulp_mbox_pkg::mbox_level_t thresh_i,
  input  pulp_mbox_pkg::timeout_t    timeout_i,
  output logic                       irq_o
);
  import pulp_mbox_pkg::*;

  timeout_t wait_cnt_q;
  logic     thresh_hit;
  logic     timeout_hit;

  // zero threshold or zero timeout disables that source
  assign thresh_hit  = (thresh_i != '0) && (rd.level >= thresh_i);
  assign timeout_hit = (timeout_i != '0) && (wait_cnt_q >= timeout_i);

  // cycles since the host last drained a word
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wait_cnt_q <= '0;
    end else if (rd.empty || rd.pop) begin
      wait_cnt_q <= '0;
    end else if (wait_cnt_q != '1) begin
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= irq_en_i && !rd.empty && (thresh_hit || timeout_hit);
    end
  end

endmodule

//--- design/mbox_regs.sv
// Mailbox register window
`timescale 1ns/100ps

module mbox_regs (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  cfg_bus_if.slave                    bus,
  mbox_rd_if.reader                   rd,
  output logic                        irq_en_o,
  output pulp_mbox_pkg::mbox_level_t  thresh_o,
  output pulp_mbox_pkg::timeout_t     timeout_o
);
  import pulp_mbox_pkg::*;

  logic      wr_en;
  logic      rd_en;
  cfg_data_t rdata_d;

  assign wr_en = bus.sel && bus.we;
  assign rd_en = bus.sel && !bus.we;

  // reading DATA drains the head word
  assign rd.pop = rd_en && (bus.offs == REG_DATA) && !rd.empty;

  // STATUS and DATA are not writable
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_en_o  <= 1'b0;
      thresh_o  <= '0;
      timeout_o <= '0;
    end else if (wr_en) begin
      case (bus.offs)
        REG_CTRL:    irq_en_o  <= bus.wdata[0];
        REG_THRESH:  thresh_o  <= bus.wdata[MBOX_LEVEL_W-1:0];
        REG_TIMEOUT: timeout_o <= bus.wdata[TIMEOUT_W-1:0];
        default:     ;
      endcase
    end
  end

  always_comb begin
    rdata_d = '0;
    case (bus.offs)
      REG_CTRL:    rdata_d = cfg_data_t'(irq_en_o);
      REG_THRESH:  rdata_d = cfg_data_t'(thresh_o);
      REG_TIMEOUT: rdata_d = cfg_data_t'(timeout_o);
      REG_STATUS:  rdata_d = cfg_data_t'(rd.level);
      REG_DATA:    if (!rd.empty) rdata_d = rd.rdata;
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      bus.rdata <= rdata_d;
    end
  end

endmodule

//--- design/pulp_mbox_if.sv
// Configuration window and mailbox read interfaces
`timescale 1ns/100ps

// one window of the configuration crossbar
interface cfg_bus_if;
  import pulp_mbox_pkg::*;

  logic      sel;
  logic      we;
  win_offs_t offs;
  cfg_data_t wdata;
  cfg_data_t rdata;

  modport master (output sel, output we, output offs, output wdata, input rdata);
  modport slave  (input sel, input we, input offs, input wdata, output rdata);
endinterface

// host side of the mailbox storage
interface mbox_rd_if;
  import pulp_mbox_pkg::*;

  logic        pop;
  cfg_data_t   rdata;
  mbox_level_t level;
  logic        empty;

  modport reader  (output pop, input rdata, input level, input empty);
  modport fifo    (input pop, output rdata, output level, output empty);
  // interrupt logic only watches
  modport monitor (input pop, input level, input empty);
endinterface

//--- design/pulp_mbox_pkg.sv
// Host mailbox and translation constants
package pulp_mbox_pkg;

  // configuration port
  localparam int unsigned CFG_AW = 32;
  localparam int unsigned CFG_DW = 32;

  typedef logic [CFG_AW-1:0] cfg_addr_t;
  typedef logic [CFG_DW-1:0] cfg_data_t;

  // address windows of the configuration crossbar
  localparam int unsigned WIN_OFFS_W = 12;
  typedef logic [WIN_OFFS_W-1:0] win_offs_t;

  localparam cfg_addr_t WIN0_BASE = 32'h0000_0000;
  localparam cfg_addr_t WIN1_BASE = 32'h0000_1000;
  localparam cfg_addr_t WIN_SIZE  = 32'h0000_1000;

  // mailbox
  localparam int unsigned MBOX_DEPTH   = 8;
  localparam int unsigned MBOX_PTR_W   = 3;
  localparam int unsigned MBOX_LEVEL_W = 4;
  typedef logic [MBOX_LEVEL_W-1:0] mbox_level_t;

  localparam int unsigned TIMEOUT_W = 16;
  typedef logic [TIMEOUT_W-1:0] timeout_t;

  // host-to-device page table, 16 bytes per entry
  localparam int unsigned XLAT_ENTRIES = 4;
  localparam int unsigned XLAT_IDX_W   = 2;
  localparam int unsigned XLAT_FLD_W   = 4;
  localparam int unsigned PAGE_OFFS_W  = 12;
  localparam int unsigned PAGE_W       = 20;
  typedef logic [PAGE_W-1:0] page_t;

  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_ACCESS,
    CFG_RESP
  } cfg_state_e;

  // window 0 register map
  typedef enum logic [WIN_OFFS_W-1:0] {
    REG_CTRL    = 12'h000,
    REG_THRESH  = 12'h004,
    REG_TIMEOUT = 12'h008,
    REG_STATUS  = 12'h00C,
    REG_DATA    = 12'h010
  } mbox_reg_e;

  // field offsets inside one table entry
  typedef enum logic [XLAT_FLD_W-1:0] {
    FLD_SRC   = 4'h0,
    FLD_DST   = 4'h4,
    FLD_VALID = 4'h8
  } xlat_field_e;

endpackage

//--- design/pulp_mbox_top.sv
// Host mailbox subsystem top
`timescale 1ns/100ps

module pulp_mbox_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // host configuration port
  input  logic                     cfg_req_i,
  input  logic                     cfg_we_i,
  input  pulp_mbox_pkg::cfg_addr_t cfg_addr_i,
  input  pulp_mbox_pkg::cfg_data_t cfg_wdata_i,
  output logic                     cfg_ack_o,
  output logic                     cfg_err_o,
  output pulp_mbox_pkg::cfg_data_t cfg_rdata_o,

  // device push side
  input  logic                     dev_wr_i,
  input  pulp_mbox_pkg::cfg_data_t dev_wdata_i,
  output logic                     dev_full_o,

  output logic                     mbox_irq_o,

  // address lookup
  input  logic                     xlat_req_i,
  input  pulp_mbox_pkg::cfg_addr_t xlat_addr_i,
  output logic                     xlat_valid_o,
  output logic                     xlat_hit_o,
  output pulp_mbox_pkg::cfg_addr_t xlat_addr_o
);
  import pulp_mbox_pkg::*;

  logic        irq_en;
  mbox_level_t thresh;
  timeout_t    timeout;

  cfg_bus_if win0_bus ();
  cfg_bus_if win1_bus ();
  mbox_rd_if mbox_rd ();

  cfg_access_fsm i_cfg_access_fsm (
    .clk_i,
    .rst_n_i,
    .cfg_req_i,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .cfg_ack_o,
    .cfg_err_o,
    .cfg_rdata_o,
    .win0        (win0_bus),
    .win1        (win1_bus)
  );

  mbox_regs i_mbox_regs (
    .clk_i,
    .rst_n_i,
    .bus       (win0_bus),
    .rd        (mbox_rd),
    .irq_en_o  (irq_en),
    .thresh_o  (thresh),
    .timeout_o (timeout)
  );

  mbox_fifo i_mbox_fifo (
    .clk_i,
    .rst_n_i,
    .push_i      (dev_wr_i),
    .push_data_i (dev_wdata_i),
    .full_o      (dev_full_o),
    .rd          (mbox_rd)
  );

  mbox_irq_timer i_mbox_irq_timer (
    .clk_i,
    .rst_n_i,
    .rd        (mbox_rd),
    .irq_en_i  (irq_en),
    .thresh_i  (thresh),
    .timeout_i (timeout),
    .irq_o     (mbox_irq_o)
  );

  xlat_table i_xlat_table (
    .clk_i,
    .rst_n_i,
    .bus          (win1_bus),
    .xlat_req_i,
    .xlat_addr_i,
    .xlat_valid_o,
    .xlat_hit_o,
    .xlat_addr_o
  );

endmodule

//--- design/xlat_table.sv
// Host-to-device page table
`timescale 1ns/100ps

module xlat_table (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  cfg_bus_if.slave                 bus,
  input  logic                     xlat_req_i,
  input  pulp_mbox_pkg::cfg_addr_t xlat_addr_i,
  output logic                     xlat_valid_o,
  output logic                     xlat_hit_o,
  output pulp_mbox_pkg::cfg_addr_t xlat_addr_o
);
  import pulp_mbox_pkg::*;

  page_t                   src_q [XLAT_ENTRIES];
  page_t                   dst_q [XLAT_ENTRIES];
  logic [XLAT_ENTRIES-1:0] valid_q;
  logic [XLAT_IDX_W-1:0]   idx;
  logic                    in_range;
  cfg_data_t               rdata_d;
  page_t                   lk_page;
  page_t                   lk_dst;
  logic                    lk_hit;

  // entry n sits at 16*n, anything past the last entry is ignored
  assign idx      = bus.offs[XLAT_FLD_W +: XLAT_IDX_W];
  assign in_range = (bus.offs >> (XLAT_FLD_W + XLAT_IDX_W)) == '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < XLAT_ENTRIES; i++) begin
        src_q[i] <= '0;
        dst_q[i] <= '0;
      end
      valid_q <= '0;
    end else if (bus.sel && bus.we && in_range) begin
      case (bus.offs[XLAT_FLD_W-1:0])
        FLD_SRC:   src_q[idx]   <= bus.wdata[PAGE_W-1:0];
        FLD_DST:   dst_q[idx]   <= bus.wdata[PAGE_W-1:0];
        FLD_VALID: valid_q[idx] <= bus.wdata[0];
        default:   ;
      endcase
    end
  end

  always_comb begin
    rdata_d = '0;
    if (in_range) begin
      case (bus.offs[XLAT_FLD_W-1:0])
        FLD_SRC:   rdata_d = cfg_data_t'(src_q[idx]);
        FLD_DST:   rdata_d = cfg_data_t'(dst_q[idx]);
        FLD_VALID: rdata_d = cfg_data_t'(valid_q[idx]);
        default:   rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.sel && !bus.we) begin
      bus.rdata <= rdata_d;
    end
  end

  // walk down so the lowest matching entry wins
  assign lk_page = xlat_addr_i[CFG_AW-1:PAGE_OFFS_W];

  always_comb begin
    lk_hit = 1'b0;
    lk_dst = '0;
    for (int i = XLAT_ENTRIES - 1; i >= 0; i--) begin
      if (valid_q[i] && (src_q[i] == lk_page)) begin
        lk_hit = 1'b1;
        lk_dst = dst_q[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      xlat_valid_o <= 1'b0;
      xlat_hit_o   <= 1'b0;
    end else begin
      xlat_valid_o <= xlat_req_i;
      xlat_hit_o   <= xlat_req_i && lk_hit;
    end
  end

  // page offset is kept, a miss passes the address through
  always_ff @(posedge clk_i) begin
    if (xlat_req_i) begin
      xlat_addr_o <= lk_hit ? {lk_dst, xlat_addr_i[PAGE_OFFS_W-1:0]} : xlat_addr_i;
    end
  end

endmodule

//--- verification/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  localparam real HALF_PERIOD  = 2.0;
  localparam int  RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // released on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- verification/tb_pulp_mbox.sv
// Mailbox subsystem testbench
`timescale 1ns/100ps

module tb_pulp_mbox;
  import pulp_mbox_pkg::*;

  localparam int N_REG    = 24;
  localparam int N_ERR    = 16;
  localparam int N_ROUNDS = 8;
  localparam int N_IRQ    = 4;
  localparam int N_LOOKUP = 40;
  // cycles per configuration access
  localparam int ACC      = 3;
  localparam int T_REG    = N_REG * 2 * ACC + 4 * ACC;
  localparam int T_ERR    = (N_ERR + 3) * ACC;
  localparam int T_MBOX   = N_ROUNDS * (15 + 10 * ACC) + 9 * ACC;
  localparam int T_IRQ    = N_IRQ * (15 * ACC + 49);
  localparam int T_XLAT   = 6 * XLAT_ENTRIES * ACC + N_LOOKUP + 1;
  localparam int MAX_CYCLES = 2 * (10 + T_REG + T_ERR + T_MBOX + T_IRQ + T_XLAT);

  logic        clk_i;
  logic        rst_n_i;
  logic        cfg_req_i;
  logic        cfg_we_i;
  cfg_addr_t   cfg_addr_i;
  cfg_data_t   cfg_wdata_i;
  logic        cfg_ack_o;
  logic        cfg_err_o;
  cfg_data_t   cfg_rdata_o;
  logic        dev_wr_i;
  cfg_data_t   dev_wdata_i;
  logic        dev_full_o;
  logic        mbox_irq_o;
  logic        xlat_req_i;
  cfg_addr_t   xlat_addr_i;
  logic        xlat_valid_o;
  logic        xlat_hit_o;
  cfg_addr_t   xlat_addr_o;

  // reference model state
  logic [31:0] lfsr_q = 32'he94e;
  cfg_data_t   mbox_q [$];
  logic        sh_irq_en;
  mbox_level_t sh_thresh;
  timeout_t    sh_timeout;
  page_t       sh_src [XLAT_ENTRIES];
  page_t       sh_dst [XLAT_ENTRIES];
  logic        sh_valid [XLAT_ENTRIES];

  string       cur_test;
  int          test_checks;
  int          test_errors;
  int          total_checks;
  int          total_errors;
  int          cycle_cnt;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  pulp_mbox_top u_pulp_mbox_top (.*);

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("%-12s %0d checks, %0d errors", cur_test, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  task automatic count_error();
    test_errors++;
  endtask

  task automatic check_data(input string what, input cfg_data_t exp, input cfg_data_t act);
    test_checks++;
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
      count_error();
    end
  endtask

  task automatic check_addr(input string what, input cfg_addr_t exp, input cfg_addr_t act);
    test_checks++;
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
      count_error();
    end
  endtask

  task automatic check_level(input string what, input mbox_level_t exp, input mbox_level_t act);
    test_checks++;
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      count_error();
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    test_checks++;
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %b, actual %b", cur_test, what, exp, act);
      count_error();
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // ack is due exactly two cycles after the accepting edge
  task automatic host_access(input logic we, input cfg_addr_t addr, input cfg_data_t wdata,
                             output logic err, output cfg_data_t rdata);
    logic early;
    cfg_req_i   = 1'b1;
    cfg_we_i    = we;
    cfg_addr_i  = addr;
    cfg_wdata_i = wdata;
    @(negedge clk_i);
    cfg_req_i = 1'b0;
    early = cfg_ack_o;
    @(negedge clk_i);
    early = early | cfg_ack_o;
    @(negedge clk_i);
    test_checks++;
    if (early !== 1'b0 || cfg_ack_o !== 1'b1) begin
      $display("%s: ack not seen exactly two cycles after the request to %h", cur_test, addr);
      count_error();
    end
    err   = cfg_err_o;
    rdata = cfg_rdata_o;
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    logic      err;
    cfg_data_t rd;
    host_access(1'b1, addr, data, err, rd);
    check_flag("write err", 1'b0, err);
  endtask

  task automatic cfg_read(input cfg_addr_t addr, output cfg_data_t data);
    logic err;
    host_access(1'b0, addr, '0, err, data);
    check_flag("read err", 1'b0, err);
  endtask

  task automatic reg_write(input mbox_reg_e r, input cfg_data_t data);
    cfg_write(WIN0_BASE + r, data);
    case (r)
      REG_CTRL:    sh_irq_en  = data[0];
      REG_THRESH:  sh_thresh  = data[MBOX_LEVEL_W-1:0];
      REG_TIMEOUT: sh_timeout = data[TIMEOUT_W-1:0];
      default:     ;
    endcase
  endtask

  function automatic cfg_data_t expected_reg(input mbox_reg_e r);
    case (r)
      REG_CTRL:    return cfg_data_t'(sh_irq_en);
      REG_THRESH:  return cfg_data_t'(sh_thresh);
      REG_TIMEOUT: return cfg_data_t'(sh_timeout);
      default:     return '0;
    endcase
  endfunction

  task automatic readback_regs();
    cfg_data_t rd;
    cfg_read(WIN0_BASE + REG_CTRL, rd);
    check_data("ctrl", expected_reg(REG_CTRL), rd);
    cfg_read(WIN0_BASE + REG_THRESH, rd);
    check_data("thresh", expected_reg(REG_THRESH), rd);
    cfg_read(WIN0_BASE + REG_TIMEOUT, rd);
    check_data("timeout", expected_reg(REG_TIMEOUT), rd);
  endtask

  // words pushed into a full mailbox are lost
  task automatic dev_push(input cfg_data_t data);
    dev_wr_i    = 1'b1;
    dev_wdata_i = data;
    @(negedge clk_i);
    dev_wr_i = 1'b0;
    if (mbox_q.size() < MBOX_DEPTH) begin
      mbox_q.push_back(data);
    end
    check_flag("full", mbox_q.size() == MBOX_DEPTH, dev_full_o);
  endtask

  task automatic pop_check();
    cfg_data_t exp;
    cfg_data_t rd;
    exp = '0;
    if (mbox_q.size() > 0) begin
      exp = mbox_q.pop_front();
    end
    cfg_read(WIN0_BASE + REG_DATA, rd);
    check_data("data", exp, rd);
  endtask

  task automatic lookup_model(input cfg_addr_t addr, output logic hit, output cfg_addr_t res);
    hit = 1'b0;
    res = addr;
    for (int n = 0; n < XLAT_ENTRIES; n++) begin
      if (!hit && sh_valid[n] && sh_src[n] == addr[CFG_AW-1:PAGE_OFFS_W]) begin
        hit = 1'b1;
        res = {sh_dst[n], addr[PAGE_OFFS_W-1:0]};
      end
    end
  endtask

  task automatic test_reset();
    cfg_data_t rd;
    start_test("reset");
    check_flag("ack", 1'b0, cfg_ack_o);
    check_flag("err", 1'b0, cfg_err_o);
    check_flag("valid", 1'b0, xlat_valid_o);
    check_flag("irq", 1'b0, mbox_irq_o);
    check_flag("full", 1'b0, dev_full_o);
    cfg_read(WIN0_BASE + REG_STATUS, rd);
    check_level("status", '0, mbox_level_t'(rd));
    end_test();
  endtask

  task automatic test_reg_access();
    mbox_reg_e r;
    cfg_data_t rd;
    start_test("reg_access");
    for (int i = 0; i < N_REG; i++) begin
      case (rand_bits(2) % 3)
        0:       r = REG_CTRL;
        1:       r = REG_THRESH;
        default: r = REG_TIMEOUT;
      endcase
      reg_write(r, rand_bits(32));
      cfg_read(WIN0_BASE + r, rd);
      check_data("readback", expected_reg(r), rd);
    end
    end_test();
  endtask

  task automatic test_decode_error();
    cfg_addr_t addr;
    cfg_data_t rd;
    logic      we;
    logic      err;
    start_test("decode_err");
    for (int i = 0; i < N_ERR; i++) begin
      addr = rand_bits(32);
      if (addr < WIN1_BASE + WIN_SIZE) begin
        addr = addr | 32'h0000_2000;
      end
      // offset of a writable register so a wrong decode would disturb it
      addr[WIN_OFFS_W-1:0] = win_offs_t'(4 * (rand_bits(2) % 3));
      we = (rand_bits(1) != 0);
      host_access(we, addr, rand_bits(32), err, rd);
      check_flag("err", 1'b1, err);
      check_data("rdata", '0, rd);
    end
    readback_regs();
    end_test();
  endtask

  task automatic test_mbox_order();
    int        n;
    cfg_data_t rd;
    start_test("mbox_order");
    for (int r = 0; r < N_ROUNDS; r++) begin
      n = rand_bits(4);
      repeat (n) dev_push(rand_bits(32));
      cfg_read(WIN0_BASE + REG_STATUS, rd);
      check_level("status", mbox_level_t'(mbox_q.size()), mbox_level_t'(rd));
      n = rand_bits(4);
      if (n > 9) begin
        n = 9;
      end
      repeat (n) pop_check();
    end
    // drain and then read once from the empty mailbox
    repeat (mbox_q.size() + 1) pop_check();
    end_test();
  endtask

  task automatic test_irq_rule();
    int          n;
    int          to;
    mbox_level_t t;
    start_test("irq_rule");
    for (int r = 0; r < N_IRQ; r++) begin
      while (mbox_q.size() > 0) begin
        pop_check();
      end
      t = 1 + rand_bits(3);
      reg_write(REG_TIMEOUT, '0);
      reg_write(REG_THRESH, t);
      reg_write(REG_CTRL, 1);
      n = 2 + rand_bits(3);
      if (n > MBOX_DEPTH) begin
        n = MBOX_DEPTH;
      end
      repeat (n) dev_push(rand_bits(32));
      idle(3);
      check_flag("thresh irq", mbox_q.size() >= t, mbox_irq_o);
      // wait counter restarts at the pop and at least one word stays
      to = 2 + rand_bits(5);
      reg_write(REG_THRESH, '0);
      reg_write(REG_TIMEOUT, to);
      pop_check();
      check_flag("irq after pop", 1'b0, mbox_irq_o);
      idle(to - 1);
      check_flag("irq before timeout", 1'b0, mbox_irq_o);
      idle(3);
      check_flag("timeout irq", 1'b1, mbox_irq_o);
      reg_write(REG_CTRL, '0);
      idle(3);
      check_flag("irq disabled", 1'b0, mbox_irq_o);
    end
    end_test();
  endtask

  task automatic test_xlat();
    page_t                   pool [4];
    page_t                   page;
    logic [PAGE_OFFS_W-1:0]  offs;
    cfg_addr_t               base;
    cfg_addr_t               addr;
    cfg_addr_t               exp_addr;
    cfg_data_t               rd;
    logic                    req;
    logic                    exp_hit;
    start_test("xlat");
    // a small page pool so that entries share source pages
    for (int i = 0; i < 4; i++) begin
      pool[i] = rand_bits(PAGE_W);
    end
    for (int n = 0; n < XLAT_ENTRIES; n++) begin
      base        = WIN1_BASE + 16 * n;
      sh_src[n]   = pool[rand_bits(2)];
      sh_dst[n]   = rand_bits(PAGE_W);
      sh_valid[n] = (rand_bits(2) != 0);
      cfg_write(base + FLD_SRC, sh_src[n]);
      cfg_write(base + FLD_DST, sh_dst[n]);
      cfg_write(base + FLD_VALID, sh_valid[n]);
    end
    for (int n = 0; n < XLAT_ENTRIES; n++) begin
      base = WIN1_BASE + 16 * n;
      cfg_read(base + FLD_SRC, rd);
      check_data("src", cfg_data_t'(sh_src[n]), rd);
      cfg_read(base + FLD_DST, rd);
      check_data("dst", cfg_data_t'(sh_dst[n]), rd);
      cfg_read(base + FLD_VALID, rd);
      check_data("valid", cfg_data_t'(sh_valid[n]), rd);
    end
    // one request per cycle with the result checked on the next falling edge
    for (int j = 0; j < N_LOOKUP; j++) begin
      req = (rand_bits(2) != 0);
      if (rand_bits(1) != 0) begin
        page = pool[rand_bits(2)];
      end else begin
        page = rand_bits(PAGE_W);
      end
      offs = rand_bits(PAGE_OFFS_W);
      addr = {page, offs};
      lookup_model(addr, exp_hit, exp_addr);
      xlat_req_i  = req;
      xlat_addr_i = addr;
      @(negedge clk_i);
      if (!req) begin
        check_flag("idle valid", 1'b0, xlat_valid_o);
      end else if (xlat_valid_o !== 1'b1) begin
        $display("%s: no lookup result one cycle after the request for %h", cur_test, addr);
        count_error();
      end else begin
        check_flag("hit", exp_hit, xlat_hit_o);
        check_addr("addr", exp_addr, xlat_addr_o);
      end
    end
    xlat_req_i = 1'b0;
    end_test();
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles before the tests finished", cycle_cnt);
    $display("Checks failed");
    $finish;
  end

  initial begin
    cfg_req_i    = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    dev_wr_i     = 1'b0;
    dev_wdata_i  = '0;
    xlat_req_i   = 1'b0;
    xlat_addr_i  = '0;
    sh_irq_en    = 1'b0;
    sh_thresh    = '0;
    sh_timeout   = '0;
    total_checks = 0;
    total_errors = 0;
    for (int n = 0; n < XLAT_ENTRIES; n++) begin
      sh_src[n]   = '0;
      sh_dst[n]   = '0;
      sh_valid[n] = 1'b0;
    end
    wait (rst_n_i === 1'b1);
    @(negedge clk_i);
    test_reset();
    test_reg_access();
    test_decode_error();
    test_mbox_order();
    test_irq_rule();
    test_xlat();
    $display("total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
design/pulp_mbox_pkg.sv
design/pulp_mbox_if.sv
design/cfg_access_fsm.sv
design/mbox_fifo.sv
design/mbox_irq_timer.sv
design/mbox_regs.sv
design/xlat_table.sv
design/pulp_mbox_top.sv
verification/tb_clk_gen.sv
verification/tb_pulp_mbox.sv
